// ==== project.f ====
+incdir+.
dma_pkg.sv
dma_fsm.sv
dram_addr_counter.sv
line_packer.sv
line_writer.sv
dma_read.sv
tb_dma_read.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the DMA read testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timescale 1ns/100ps --top-module tb_dma_read -f project.f; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_dma_read)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

// ==== tb_dma_read.sv ====
`include "dma_settings.svh"

module tb_dma_read;
	timeunit 1ns;
	timeprecision 100ps;
	import dma_pkg::*;

	localparam int N_XFERS = 30;
	localparam int DONE_TIMEOUT = 400;
	localparam int WT_BITS = `WT_LINE_WORDS * `DMA_WORD_W;
	localparam int IN_BITS = `IN_LINE_WORDS * `DMA_WORD_W;

	logic                   clk = 1'b0;
	logic                   rst;
	logic                   start;
	dma_cfg_t               cfg;
	logic                   done;
	dram_cmd_t              dram_cmd;
	logic [`DMA_WORD_W-1:0] dram_q = '0;
	in_wr_t                 in_wr [`IN_BUFS];
	wt_wr_t                 wt_wr;

	logic [31:0] rng = 32'h9b1e968c;
	logic        busy;
	int          xfer_id = 0;
	int          n_words;
	int          n_lines;
	int          line_words;

	// scoreboard state, owned by the checker
	int                   seen_id = 0;
	int                   rd_idx = 0;
	int                   ln_idx = 0;
	int                   done_cnt = 0;
	int                   lines_total = 0;
	logic                 act_seen = 1'b0;
	logic [`DRAM_A_W-1:0] act_row = '0;

	int chk_errors = 0;
	int end_errors = 0;
	int prop_errors = 0;
	int timeouts = 0;

	logic [`DRAM_A_W-1:0] dram_row = '0;
	logic                 rd_pend = 1'b0;
	logic [31:0]          rd_addr = '0;

	always #5 clk = ~clk;

	dma_read dut0 (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.cfg      (cfg),
		.done     (done),
		.dram_cmd (dram_cmd),
		.dram_q   (dram_q),
		.in_wr    (in_wr),
		.wt_wr    (wt_wr)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// model words of one line, first word ends up on top
	function automatic logic [WT_BITS-1:0] expected_line(input logic [31:0] base,
		input int line, input int n);
		logic [WT_BITS-1:0] acc;
		acc = '0;
		for (int j = 0; j < n; j++)
			acc = {acc[WT_BITS-`DMA_WORD_W-1:0], xorshift32(base + 32'((line * n + j) * 4))};
		return acc;
	endfunction

	// dram model, data one cycle after the column read
	always @(negedge clk)
	begin
		if (rd_pend)
			dram_q <= xorshift32(rd_addr);
		rd_pend <= !dram_cmd.cas_n;
		rd_addr <= {8'h00, dram_row, dram_cmd.a[9:0], 2'b00};
		if (!dram_cmd.ras_n)
			dram_row <= dram_cmd.a;
	end

	always @(negedge clk)
	begin
		logic [31:0]                    exp_addr;
		logic [WT_BITS-1:0]             exp_line;
		logic                           wr_in;
		logic                           wr_wt;
		logic                           sel;
		logic [$clog2(`WT_BANKS)-1:0]   bank;
		if (xfer_id != seen_id)
		begin
			seen_id = xfer_id;
			rd_idx = 0;
			ln_idx = 0;
			done_cnt = 0;
			act_seen = 1'b0;
		end
		wr_in = !(in_wr[0].cen && in_wr[0].wen && in_wr[1].cen && in_wr[1].wen);
		wr_wt = (wt_wr.wen != '1);
		sel = cfg.buf_select;
		bank = cfg.weight_addr_start[`WT_BANK_LSB +: $clog2(`WT_BANKS)];
		exp_addr = cfg.dram_addr_start + 32'(rd_idx * 4);
		if (rst || !busy)
		begin
			assert (!done && dram_cmd.ras_n && dram_cmd.cas_n && !wr_in && !wr_wt)
			else
			begin
				chk_errors++;
				$display("[FAIL] %0t: idle outputs active, done=%b cmd=%h in=%b wt=%b",
					$time, done, dram_cmd, wr_in, wr_wt);
			end
		end
		else
		begin
			if (!dram_cmd.ras_n)
			begin
				act_row = dram_cmd.a;
				act_seen = 1'b1;
			end
			if (!dram_cmd.cas_n)
			begin
				assert (rd_idx < n_words
					&& dram_cmd.a == `DRAM_A_W'(exp_addr[`DMA_COL_MSB:`DMA_COL_LSB])
					&& act_row == exp_addr[`DMA_ROW_MSB:`DMA_ROW_LSB])
				else
				begin
					chk_errors++;
					$display("[FAIL] %0t: read %0d row %h col %h, expected address %h",
						$time, rd_idx, act_row, dram_cmd.a, exp_addr);
				end
				// first read and column zero need a fresh activate
				assert (act_seen || (rd_idx != 0 && exp_addr[`DMA_COL_MSB:`DMA_COL_LSB] != '0))
				else
				begin
					chk_errors++;
					$display("[FAIL] %0t: read %0d without an activate", $time, rd_idx);
				end
				act_seen = 1'b0;
				rd_idx++;
			end
			if (wr_in || wr_wt)
			begin
				exp_line = expected_line(cfg.dram_addr_start, ln_idx, line_words);
				if (cfg.target == TGT_INPUT)
				begin
					assert (!wr_wt && !in_wr[sel].cen && !in_wr[sel].wen && in_wr[!sel].cen
						&& in_wr[!sel].wen
						&& in_wr[sel].a == cfg.buf_addr_start + `IN_BUF_AW'(ln_idx)
						&& in_wr[sel].di == exp_line[IN_BITS-1:0])
					else
					begin
						chk_errors++;
						$display("[FAIL] %0t: input line %0d buf %0d a=%h di=%h, expected di=%h",
							$time, ln_idx, sel, in_wr[sel].a, in_wr[sel].di,
							exp_line[IN_BITS-1:0]);
					end
				end
				else
				begin
					assert (!wr_in && wt_wr.wen == ~(`WT_BANKS'(1) << bank)
						&& wt_wr.a == cfg.weight_addr_start[`WT_AW-1:0] + `WT_AW'(ln_idx)
						&& wt_wr.di == exp_line)
					else
					begin
						chk_errors++;
						$display("[FAIL] %0t: weight line %0d wen=%h a=%h, expected bank %0d",
							$time, ln_idx, wt_wr.wen, wt_wr.a, bank);
					end
				end
				assert (ln_idx < n_lines && done == (ln_idx == n_lines - 1))
				else
				begin
					chk_errors++;
					$display("[FAIL] %0t: line write %0d of %0d with done=%b",
						$time, ln_idx, n_lines, done);
				end
				ln_idx++;
				lines_total++;
			end
			else
			begin
				assert (!done)
				else
				begin
					chk_errors++;
					$display("[FAIL] %0t: done without a line write", $time);
				end
			end
			if (done)
				done_cnt++;
		end
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
	else
	begin
		prop_errors++;
		$display("[FAIL] %0t: done high for more than one cycle", $time);
	end

	a_no_ras_cas: assert property (@(posedge clk) disable iff (rst)
		!(!dram_cmd.ras_n && !dram_cmd.cas_n))
	else
	begin
		prop_errors++;
		$display("[FAIL] %0t: ras_n and cas_n low together", $time);
	end

	task automatic wait_for_done(input int idx, output logic seen);
		seen = 1'b0;
		for (int cyc = 0; cyc < DONE_TIMEOUT && !seen; cyc++)
		begin
			@(negedge clk);
			seen = done;
		end
		if (!seen)
		begin
			timeouts++;
			$display("timeout: transfer %0d saw no done within %0d cycles", idx, DONE_TIMEOUT);
		end
	endtask

	task automatic run_transfer(input int idx, output logic ok);
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		logic [9:0]  col;
		r1 = next_rand();
		r2 = next_rand();
		r3 = next_rand();
		cfg.target = (idx < 2) ? target_e'(idx[0]) : target_e'(r1[0]);
		cfg.buf_select = r1[1];
		line_words = (cfg.target == TGT_INPUT) ? `IN_LINE_WORDS : `WT_LINE_WORDS;
		n_lines = int'(r1 % 32'd6) + 1;
		n_words = n_lines * line_words;
		col = r2[21:12];
		// some starts sit just before a row end
		if (r2[31])
			col = 10'd1023 - 10'(r2[24:22]);
		cfg.dram_addr_start = {8'h00, 12'(r2 % 32'd4095), col, 2'b00};
		cfg.dram_addr_end = cfg.dram_addr_start + 32'((n_words - 1) * 4);
		cfg.buf_addr_start = r3[6:0];
		cfg.weight_addr_start = r3[24:7];
		xfer_id++;
		busy = 1'b1;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		wait_for_done(idx, ok);
		if (ok)
		begin
			@(negedge clk);
			assert (done_cnt == 1 && ln_idx == n_lines && rd_idx == n_words)
			else
			begin
				end_errors++;
				$display("[FAIL] %0t: transfer %0d ended with %0d done, %0d lines, %0d reads",
					$time, idx, done_cnt, ln_idx, rd_idx);
			end
			busy = 1'b0;
		end
	endtask

	initial
	begin
		logic ok;
		rst = 1'b1;
		start = 1'b0;
		cfg = '0;
		busy = 1'b0;
		ok = 1'b1;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		for (int i = 0; i < N_XFERS && ok; i++)
			run_transfer(i, ok);
		$display("lines=%0d check errors=%0d end errors=%0d property errors=%0d timeouts=%0d",
			lines_total, chk_errors, end_errors, prop_errors, timeouts);
		if (chk_errors + end_errors + prop_errors + timeouts == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== dma_read.sv ====
`include "dma_settings.svh"

module dma_read (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  dma_pkg::dma_cfg_t       cfg,
	output logic                    done,
	output dma_pkg::dram_cmd_t      dram_cmd,
	input  logic [`DMA_WORD_W-1:0]  dram_q,
	output dma_pkg::in_wr_t         in_wr [`IN_BUFS],
	output dma_pkg::wt_wr_t         wt_wr
);
	import dma_pkg::*;

	logic       load;
	logic       rd_valid;
	logic       row_wrap;
	logic       last_word;
	dma_state_e state;
	in_line_t   in_line;
	wt_line_t   wt_line;

	dma_fsm u_fsm (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.target    (cfg.target),
		.rd_valid  (rd_valid),
		.row_wrap  (row_wrap),
		.last_word (last_word),
		.load      (load),
		.state     (state),
		.done      (done)
	);

	dram_addr_counter u_addr (
		.clk       (clk),
		.rst       (rst),
		.load      (load),
		.cfg       (cfg),
		.state     (state),
		.dram_cmd  (dram_cmd),
		.rd_valid  (rd_valid),
		.row_wrap  (row_wrap),
		.last_word (last_word)
	);

	// both packers see every word, the writer picks one line
	line_packer #(.line_t(in_line_t)) u_in_pack (
		.clk     (clk),
		.rst     (rst),
		.capture (rd_valid),
		.word    (dram_q),
		.line    (in_line)
	);

	line_packer #(.line_t(wt_line_t)) u_wt_pack (
		.clk     (clk),
		.rst     (rst),
		.capture (rd_valid),
		.word    (dram_q),
		.line    (wt_line)
	);

	line_writer u_writer (
		.clk     (clk),
		.rst     (rst),
		.load    (load),
		.cfg     (cfg),
		.state   (state),
		.in_line (in_line),
		.wt_line (wt_line),
		.in_wr   (in_wr),
		.wt_wr   (wt_wr)
	);

endmodule

// ==== line_writer.sv ====
`include "dma_settings.svh"

module line_writer (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 load,
	input  dma_pkg::dma_cfg_t    cfg,
	input  dma_pkg::dma_state_e  state,
	input  dma_pkg::in_line_t    in_line,
	input  dma_pkg::wt_line_t    wt_line,
	output dma_pkg::in_wr_t      in_wr [`IN_BUFS],
	output dma_pkg::wt_wr_t      wt_wr
);
	import dma_pkg::*;

	localparam int BANK_W = $clog2(`WT_BANKS);

	target_e               tgt;
	logic                  buf_sel;
	logic [BANK_W-1:0]     bank;
	logic [`IN_BUF_AW-1:0] line_addr;
	logic                  wr_en;

	assign wr_en = (state == S_WRITE);

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			tgt <= TGT_INPUT;
			buf_sel <= 1'b0;
			bank <= '0;
			line_addr <= '0;
		end
		else if (load)
		begin
			tgt <= cfg.target;
			buf_sel <= cfg.buf_select;
			bank <= cfg.weight_addr_start[`WT_BANK_LSB +: BANK_W];
			if (cfg.target == TGT_INPUT)
				line_addr <= cfg.buf_addr_start;
			else
				line_addr <= `IN_BUF_AW'(cfg.weight_addr_start[`WT_AW-1:0]);
		end
		else if (wr_en)
			line_addr <= line_addr + 1'b1;
	end

	always_comb
	begin
		for (int i = 0; i < `IN_BUFS; i++)
		begin
			in_wr[i].cen = !(wr_en && tgt == TGT_INPUT && buf_sel == 1'(i));
			in_wr[i].wen = !(wr_en && tgt == TGT_INPUT && buf_sel == 1'(i));
			in_wr[i].a = line_addr;
			in_wr[i].di = in_line;
		end
		// active low, one bank per transfer
		wt_wr.wen = '1;
		if (wr_en && tgt == TGT_WEIGHT)
			wt_wr.wen[bank] = 1'b0;
		wt_wr.a = `WT_AW'(line_addr);
		wt_wr.di = wt_line;
	end

	a_one_bank: assert property (@(posedge clk) disable iff (rst)
		$onehot0(~wt_wr.wen))
		else $error("more than one weight bank written");

endmodule

// ==== line_packer.sv ====
`include "dma_settings.svh"

module line_packer #(
	parameter type line_t = logic [2*`DMA_WORD_W-1:0]
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    capture,
	input  logic [`DMA_WORD_W-1:0]  word,
	output line_t                   line
);
	localparam int LINE_W = $bits(line_t);

	logic [LINE_W-1:0] shreg;

	// oldest word moves up toward the msbs
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			shreg <= '0;
		else if (capture)
			shreg <= {shreg[LINE_W-`DMA_WORD_W-1:0], word};
	end

	assign line = line_t'(shreg);

endmodule

// ==== dram_addr_counter.sv ====
`include "dma_settings.svh"

module dram_addr_counter (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 load,
	input  dma_pkg::dma_cfg_t    cfg,
	input  dma_pkg::dma_state_e  state,
	output dma_pkg::dram_cmd_t   dram_cmd,
	output logic                 rd_valid,
	output logic                 row_wrap,
	output logic                 last_word
);
	import dma_pkg::*;

	logic [`DMA_ADDR_W-1:0] addr;
	logic [`DMA_ADDR_W-1:0] addr_nxt;
	logic [`DMA_ADDR_W-1:0] addr_end;
	logic                   col_rd;

	assign col_rd = (state == S_READ);
	assign addr_nxt = addr + `DMA_ADDR_W'(4);
	assign last_word = (addr == addr_end);

	// during a read addr is the word on the bus, so look one word ahead
	assign row_wrap = col_rd ? (addr_nxt[`DMA_COL_MSB:`DMA_COL_LSB] == '0)
		: (addr[`DMA_COL_MSB:`DMA_COL_LSB] == '0);

	always_comb
	begin
		dram_cmd.ras_n = (state != S_ACT);
		dram_cmd.cas_n = !col_rd;
		dram_cmd.a = '0;
		if (state == S_ACT)
			dram_cmd.a = addr[`DMA_ROW_MSB:`DMA_ROW_LSB];
		else if (col_rd)
			dram_cmd.a = `DRAM_A_W'(addr[`DMA_COL_MSB:`DMA_COL_LSB]);
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			addr <= '0;
			addr_end <= '0;
			rd_valid <= 1'b0;
		end
		else
		begin
			if (load)
			begin
				addr <= cfg.dram_addr_start;
				addr_end <= cfg.dram_addr_end;
			end
			else if (col_rd)
				addr <= addr_nxt;
			// fixed one-cycle read latency
			rd_valid <= col_rd;
		end
	end

	a_word_aligned: assert property (@(posedge clk) disable iff (rst)
		col_rd |-> (addr[1:0] == 2'b00))
		else $error("column read from an unaligned address");

	a_ras_cas: assert property (@(posedge clk) disable iff (rst)
		!(!dram_cmd.ras_n && !dram_cmd.cas_n))
		else $error("ras_n and cas_n low together");

endmodule

// ==== dma_fsm.sv ====
`include "dma_settings.svh"

module dma_fsm (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  dma_pkg::target_e     target,
	input  logic                 rd_valid,
	input  logic                 row_wrap,
	input  logic                 last_word,
	output logic                 load,
	output dma_pkg::dma_state_e  state,
	output logic                 done
);
	import dma_pkg::*;

	localparam logic [3:0] IN_LAST = 4'(`IN_LINE_WORDS - 1);
	localparam logic [3:0] WT_LAST = 4'(`WT_LINE_WORDS - 1);

	dma_state_e state_nxt;
	target_e    tgt;
	logic [3:0] word_cnt;
	logic       line_end;
	logic       end_seen;
	logic       act_seen;

	assign load = (state == S_IDLE) && start;
	assign line_end = (word_cnt == ((tgt == TGT_INPUT) ? IN_LAST : WT_LAST));
	assign done = (state == S_WRITE) && end_seen;

	always_comb
	begin
		state_nxt = state;
		case (state)
			S_IDLE:
				if (start)
					state_nxt = S_ACT;
			S_ACT:
				state_nxt = S_READ;
			S_READ:
				if (line_end || last_word)
					state_nxt = S_WAIT;
				else if (row_wrap)
					state_nxt = S_ACT;
			// last word of the line is on dram_q here
			S_WAIT:
				if (rd_valid)
					state_nxt = S_WRITE;
			S_WRITE:
				if (end_seen)
					state_nxt = S_IDLE;
				else if (row_wrap)
					state_nxt = S_ACT;
				else
					state_nxt = S_READ;
			default:
				state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			state <= S_IDLE;
			tgt <= TGT_INPUT;
			word_cnt <= '0;
			end_seen <= 1'b0;
			act_seen <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			if (load)
				tgt <= target;
			// column reads issued in the current line
			if (load || state == S_WRITE)
				word_cnt <= '0;
			else if (state == S_READ)
				word_cnt <= word_cnt + 4'd1;
			if (load)
				end_seen <= 1'b0;
			else if (state == S_READ && last_word)
				end_seen <= 1'b1;
			if (load)
				act_seen <= 1'b0;
			else if (state == S_ACT)
				act_seen <= 1'b1;
		end
	end

	a_read_after_act: assert property (@(posedge clk) disable iff (rst)
		(state == S_READ) |-> act_seen)
		else $error("column read without a row activate since load");

endmodule

// ==== dma_pkg.sv ====
`include "dma_settings.svh"

package dma_pkg;

	typedef enum logic {
		TGT_INPUT,
		TGT_WEIGHT
	} target_e;

	typedef enum logic [2:0] {
		S_IDLE,
		S_ACT,
		S_READ,
		S_WAIT,
		S_WRITE
	} dma_state_e;

	typedef struct packed {
		target_e                 target;
		logic                    buf_select;
		logic [`DMA_ADDR_W-1:0]  dram_addr_start;
		logic [`DMA_ADDR_W-1:0]  dram_addr_end;
		logic [`IN_BUF_AW-1:0]   buf_addr_start;
		logic [`WT_START_W-1:0]  weight_addr_start;
	} dma_cfg_t;

	typedef struct packed {
		logic                  ras_n;
		logic                  cas_n;
		logic [`DRAM_A_W-1:0]  a;
	} dram_cmd_t;

	// first word read lands in the top element
	typedef logic [`IN_LINE_WORDS-1:0][`DMA_WORD_W-1:0] in_line_t;
	typedef logic [`WT_LINE_WORDS-1:0][`DMA_WORD_W-1:0] wt_line_t;

	typedef struct packed {
		logic                   cen;
		logic                   wen;
		logic [`IN_BUF_AW-1:0]  a;
		in_line_t               di;
	} in_wr_t;

	// one wen per bank, address and data shared
	typedef struct packed {
		logic [`WT_BANKS-1:0]  wen;
		logic [`WT_AW-1:0]     a;
		wt_line_t              di;
	} wt_wr_t;

endpackage

// ==== dma_settings.svh ====
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// DRAM side
`define DMA_WORD_W 32
`define DMA_ADDR_W 32
`define DRAM_A_W 12

// byte address fields
`define DMA_ROW_LSB 12
`define DMA_ROW_MSB 23
`define DMA_COL_LSB 2
`define DMA_COL_MSB 11

// line sizes in words
`define IN_LINE_WORDS 4
`define WT_LINE_WORDS 9

// on-chip SRAM
`define IN_BUFS 2
`define IN_BUF_AW 7
`define WT_AW 7
`define WT_BANKS 32
`define WT_BANK_LSB 7
`define WT_START_W 18

`endif
